/* eq_pkg.sv */
// Sizes are fixed for one bin half of four bins. COL_NUM must equal 2**COL_IDX_WIDTH.
`default_nettype none

package eq_pkg;

    // ======================================================================
    // Sizes
    // ======================================================================
    // Bins served by this half
    localparam int BIN_HALF         = 4;
    // Vertices per row
    localparam int COL_NUM          = 4;
    // Rows per bin
    localparam int ROW_NUM          = 16;
    localparam int DELTA_WIDTH      = 16;

    // ======================================================================
    // Vertex index layout, row | bin | column from MSB down
    // ======================================================================
    localparam int COL_IDX_WIDTH    = 2;
    localparam int BIN_IDX_WIDTH    = 2;
    localparam int ROW_IDX_WIDTH    = 4;
    localparam int BIN_IDX_LSB      = 2;
    // Row field sits right above the bin field
    localparam int ROW_IDX_LSB      = BIN_IDX_LSB + BIN_IDX_WIDTH;
    localparam int VERTEX_IDX_WIDTH = 8;

    // ======================================================================
    // Vector types
    // ======================================================================
    typedef logic [DELTA_WIDTH-1:0]      delta_t;
    typedef logic [VERTEX_IDX_WIDTH-1:0] vertex_idx_t;
    typedef logic [ROW_IDX_WIDTH-1:0]    row_idx_t;
    typedef logic [BIN_IDX_WIDTH-1:0]    bin_idx_t;
    typedef logic [COL_IDX_WIDTH-1:0]    col_idx_t;
    // One flag per bin
    typedef logic [BIN_HALF-1:0]         bin_mask_t;

endpackage

`default_nettype wire

/* event_bin.sv */
// Bin field of cu_idx_i ignored. Sums wrap at DELTA_WIDTH bits. pop_i must target a non-empty bin
`timescale 1ns/10ps
`default_nettype none

module event_bin (
    input  wire                    clk_i,
    input  wire                    arst_n_i,
    // Crossbar lane
    input  wire eq_pkg::delta_t    cu_delta_i,
    input  wire eq_pkg::vertex_idx_t cu_idx_i,
    input  wire                    cu_valid_i,
    output logic                   cu_ready_o,
    // Pop strobe from the scheduler
    input  wire                    pop_i,
    output logic                   bin_valid_o,
    // Lowest occupied row, valid while bin_valid_o
    output eq_pkg::row_idx_t       row_idx_o,
    output eq_pkg::delta_t [eq_pkg::COL_NUM-1:0] row_delta_o
);

    // ======================================================================
    // Storage
    // ======================================================================
    // Delta rows, zero when unoccupied
    eq_pkg::delta_t [eq_pkg::COL_NUM-1:0] row_mem [eq_pkg::ROW_NUM];
    // Occupancy per row
    logic [eq_pkg::ROW_NUM-1:0] occ_q;

    eq_pkg::row_idx_t wr_row;
    eq_pkg::col_idx_t wr_col;
    logic             wr_en;
    eq_pkg::row_idx_t low_row;
    logic             any_occ;

    // Field extraction, bin bits skipped
    assign wr_row = cu_idx_i[eq_pkg::ROW_IDX_LSB +: eq_pkg::ROW_IDX_WIDTH];
    assign wr_col = cu_idx_i[0 +: eq_pkg::COL_IDX_WIDTH];

    // Stall the lane only while this bin pops
    assign cu_ready_o = ~pop_i;
    assign wr_en      = cu_valid_i & cu_ready_o;

    // ======================================================================
    // Lowest occupied row
    // ======================================================================
    always_comb begin
        low_row = '0;
        // Scan downward so the lowest set flag wins
        for (int r = eq_pkg::ROW_NUM - 1; r >= 0; r--) begin
            if (occ_q[r]) begin
                low_row = eq_pkg::row_idx_t'(r);
            end
        end
    end

    assign any_occ     = |occ_q;
    assign bin_valid_o = any_occ;
    assign row_idx_o   = low_row;
    assign row_delta_o = row_mem[low_row];

    // ======================================================================
    // Accumulate and pop
    // ======================================================================
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            occ_q <= '0;
            // Rows start from zero so a first write is a plain store
            for (int r = 0; r < eq_pkg::ROW_NUM; r++) begin
                row_mem[r] <= '0;
            end
        end else begin
            // Add into the column, wraps on overflow
            if (wr_en) begin
                row_mem[wr_row][wr_col] <= row_mem[wr_row][wr_col] + cu_delta_i;
                occ_q[wr_row]           <= 1'b1;
            end
            // Popped row is zeroed for the next round of updates
            if (pop_i && any_occ) begin
                row_mem[low_row] <= '0;
                occ_q[low_row]   <= 1'b0;
            end
        end
    end

    // An accepted update is never wiped by a pop at the same edge
    a_pop_no_write: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        cu_valid_i && cu_ready_o |=> occ_q[$past(wr_row)]
    );

    // Scheduler only pops an occupied bin
    a_pop_occupied: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        pop_i |-> bin_valid_o
    );

endmodule

`default_nettype wire

/* queue_scheduler.sv */
// Pop strobes are combinational from bin_valid_i and out_free_i. Search starts at bin 0 after reset.
`timescale 1ns/10ps
`default_nettype none

module queue_scheduler (
    input  wire                clk_i,
    input  wire                arst_n_i,
    input  wire                initial_finish_i,
    input  wire                read_en_i,
    input  wire eq_pkg::bin_mask_t bin_valid_i,
    // Output stage can take a row this cycle
    input  wire                out_free_i,
    output eq_pkg::bin_mask_t  bin_selected_o
);

    // Last granted bin
    eq_pkg::bin_idx_t last_q;
    eq_pkg::bin_idx_t grant_idx;
    logic             found;
    logic             grant_en;

    // ======================================================================
    // Round-robin search after last grant
    // ======================================================================
    always_comb begin
        eq_pkg::bin_idx_t cand;
        grant_idx = last_q;
        found     = 1'b0;
        for (int k = 1; k <= eq_pkg::BIN_HALF; k++) begin
            // Index width wraps the rotation
            cand = eq_pkg::bin_idx_t'(last_q + k);
            if (!found && bin_valid_i[cand]) begin
                grant_idx = cand;
                found     = 1'b1;
            end
        end
    end

    assign grant_en       = initial_finish_i & read_en_i & out_free_i & found;
    assign bin_selected_o = grant_en ? eq_pkg::bin_mask_t'(1) << grant_idx : '0;

    // Pointer starts at the top so bin 0 is searched first
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            last_q <= eq_pkg::bin_idx_t'(eq_pkg::BIN_HALF - 1);
        end else if (grant_en) begin
            last_q <= grant_idx;
        end
    end

    // Exactly one pop whenever enabled, a bin holds data and the output has room
    a_sel_onehot: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        initial_finish_i && read_en_i && out_free_i && (bin_valid_i != '0)
            |-> $onehot(bin_selected_o)
    );

    // Last granted bin goes again only when no other bin holds data
    a_sel_rotate: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        bin_selected_o[last_q] |-> (bin_valid_i == (eq_pkg::bin_mask_t'(1) << last_q))
    );

endmodule

`default_nettype wire

/* event_queues_half.sv */
// bin_selected_i must be one-hot or zero and may only pop while out_free_o is high.
`timescale 1ns/10ps
`default_nettype none

module event_queues_half (
    input  wire                clk_i,
    input  wire                arst_n_i,
    // Crossbar lanes, one per bin
    input  wire eq_pkg::delta_t    [eq_pkg::BIN_HALF-1:0] cu_delta_i,
    input  wire eq_pkg::vertex_idx_t [eq_pkg::BIN_HALF-1:0] cu_idx_i,
    input  wire eq_pkg::bin_mask_t cu_valid_i,
    output eq_pkg::bin_mask_t      cu_ready_o,
    // Scheduler side
    output eq_pkg::bin_mask_t      bin_valid_o,
    input  wire eq_pkg::bin_mask_t bin_selected_i,
    output logic                   out_free_o,
    // Output buffer side
    output eq_pkg::row_idx_t       row_idx_o,
    output eq_pkg::bin_idx_t       bin_idx_o,
    output eq_pkg::delta_t [eq_pkg::COL_NUM-1:0] row_delta_o,
    output logic                   row_valid_o,
    input  wire                    row_ready_i
);

    // Per-bin head rows
    eq_pkg::row_idx_t                     bin_row_idx   [eq_pkg::BIN_HALF];
    eq_pkg::delta_t [eq_pkg::COL_NUM-1:0] bin_row_delta [eq_pkg::BIN_HALF];

    eq_pkg::bin_idx_t sel_idx;
    logic             pop;

    // Output register
    logic                                 row_valid_q;
    eq_pkg::row_idx_t                     row_idx_q;
    eq_pkg::bin_idx_t                     bin_idx_q;
    eq_pkg::delta_t [eq_pkg::COL_NUM-1:0] row_delta_q;

    // ======================================================================
    // Bin array
    // ======================================================================
    for (genvar g = 0; g < eq_pkg::BIN_HALF; g++) begin : g_bin
        event_bin u_bin (
            .clk_i       (clk_i),
            .arst_n_i    (arst_n_i),
            .cu_delta_i  (cu_delta_i[g]),
            .cu_idx_i    (cu_idx_i[g]),
            .cu_valid_i  (cu_valid_i[g]),
            .cu_ready_o  (cu_ready_o[g]),
            .pop_i       (bin_selected_i[g]),
            .bin_valid_o (bin_valid_o[g]),
            .row_idx_o   (bin_row_idx[g]),
            .row_delta_o (bin_row_delta[g])
        );
    end

    // ======================================================================
    // Selection and output stage
    // ======================================================================
    // One-hot to index, OR of set positions
    always_comb begin
        sel_idx = '0;
        for (int b = 0; b < eq_pkg::BIN_HALF; b++) begin
            if (bin_selected_i[b]) begin
                sel_idx = sel_idx | eq_pkg::bin_idx_t'(b);
            end
        end
    end

    assign pop        = |bin_selected_i;
    // Empty, or the held row leaves this cycle
    assign out_free_o = ~row_valid_q | row_ready_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            row_valid_q <= 1'b0;
        end else if (pop) begin
            row_valid_q <= 1'b1;
        end else if (row_ready_i) begin
            row_valid_q <= 1'b0;
        end
    end

    // Payload follows the pop, held otherwise
    always_ff @(posedge clk_i) begin
        if (pop) begin
            row_idx_q   <= bin_row_idx[sel_idx];
            bin_idx_q   <= sel_idx;
            row_delta_q <= bin_row_delta[sel_idx];
        end
    end

    assign row_valid_o = row_valid_q;
    assign row_idx_o   = row_idx_q;
    assign bin_idx_o   = bin_idx_q;
    assign row_delta_o = row_delta_q;

    // Back-pressure holds the row until the buffer takes it
    a_out_stable: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        row_valid_o && !row_ready_i |=> row_valid_o && $stable(row_idx_o)
            && $stable(bin_idx_o) && $stable(row_delta_o)
    );

endmodule

`default_nettype wire

/* eq_wrapper_half.sv */
// Flat lane i occupies bits from i*width upward. Output buffer and crossbar are outside.
`timescale 1ns/10ps
`default_nettype none

module eq_wrapper_half (
    input  wire                clk_i,
    input  wire                arst_n_i,
    input  wire                initialFinish_i,
    // Crossbar side, flat lanes
    input  wire [eq_pkg::BIN_HALF*eq_pkg::DELTA_WIDTH-1:0]      CUDelta_i,
    input  wire [eq_pkg::BIN_HALF*eq_pkg::VERTEX_IDX_WIDTH-1:0] CUIdx_i,
    input  wire eq_pkg::bin_mask_t CUValid_i,
    output eq_pkg::bin_mask_t      CUReady_o,
    // High while a bin holds no rows
    output eq_pkg::bin_mask_t      CUClean_o,
    input  wire                    readEn_i,
    // Output buffer side
    output eq_pkg::row_idx_t       rowIdx_o,
    output eq_pkg::bin_idx_t       binIdx_o,
    output logic [eq_pkg::COL_NUM*eq_pkg::DELTA_WIDTH-1:0] rowDelta_o,
    output logic                   rowValid_o,
    input  wire                    rowReady_i
);

    eq_pkg::delta_t      [eq_pkg::BIN_HALF-1:0] cu_delta;
    eq_pkg::vertex_idx_t [eq_pkg::BIN_HALF-1:0] cu_idx;
    eq_pkg::delta_t      [eq_pkg::COL_NUM-1:0]  row_delta;
    eq_pkg::bin_mask_t                          bin_valid;
    eq_pkg::bin_mask_t                          bin_selected;
    logic                                       out_free;

    // ======================================================================
    // Flat vectors to lanes and columns
    // ======================================================================
    for (genvar i = 0; i < eq_pkg::BIN_HALF; i++) begin : g_lane
        assign cu_delta[i] = CUDelta_i[i*eq_pkg::DELTA_WIDTH +: eq_pkg::DELTA_WIDTH];
        assign cu_idx[i]   = CUIdx_i[i*eq_pkg::VERTEX_IDX_WIDTH +: eq_pkg::VERTEX_IDX_WIDTH];
    end

    for (genvar c = 0; c < eq_pkg::COL_NUM; c++) begin : g_col
        assign rowDelta_o[c*eq_pkg::DELTA_WIDTH +: eq_pkg::DELTA_WIDTH] = row_delta[c];
    end

    assign CUClean_o = ~bin_valid;

    // ======================================================================
    // Queues and scheduler
    // ======================================================================
    event_queues_half u_queues (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .cu_delta_i     (cu_delta),
        .cu_idx_i       (cu_idx),
        .cu_valid_i     (CUValid_i),
        .cu_ready_o     (CUReady_o),
        .bin_valid_o    (bin_valid),
        .bin_selected_i (bin_selected),
        .out_free_o     (out_free),
        .row_idx_o      (rowIdx_o),
        .bin_idx_o      (binIdx_o),
        .row_delta_o    (row_delta),
        .row_valid_o    (rowValid_o),
        .row_ready_i    (rowReady_i)
    );

    queue_scheduler u_sched (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .initial_finish_i (initialFinish_i),
        .read_en_i        (readEn_i),
        .bin_valid_i      (bin_valid),
        .out_free_i       (out_free),
        .bin_selected_o   (bin_selected)
    );

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
// Testbench clock and power-on reset; reset is released 1 ns after its last rising edge
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS  = 10,
    parameter int RST_CYCLES = 5
) (
    output logic clk_o,
    output logic arst_n_o
);

    // Free-running clock
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset held low over RST_CYCLES rising edges
    initial begin
        arst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1;
        arst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

/* tb_eq_wrapper_half.sv */
// Table entries must keep the bin field equal to the lane; drain order assumes no writes meanwhile
`timescale 1ns/10ps
`default_nettype none

module tb_eq_wrapper_half;

    localparam int NB         = eq_pkg::BIN_HALF;
    localparam int DW         = eq_pkg::DELTA_WIDTH;
    localparam int RST_CYCLES = 5;
    localparam int TBL_LEN    = 17;
    // First load ends here, the rest is the reload
    localparam int TBL1_LEN   = 14;

    // ======================================================================
    // Stimulus table
    // ======================================================================
    // Columns: lane | row | col | 0 | delta (16 bits)
    localparam logic [31:0] STIM_TBL [TBL_LEN] = '{
        // Bin 0, column 0 wraps to 0x0008, row 5 sparse
        32'h0000_0010, 32'h0000_FFF8, 32'h0030_1234, 32'h0510_0001,
        // Bin 1, 0x8000 + 0x8001 wraps to 0x0001
        32'h1220_8000, 32'h1220_8001, 32'h1F00_ABCD,
        // Bin 2, three hits on one vertex
        32'h2730_0042, 32'h2300_0100, 32'h2300_0100, 32'h2300_0100,
        // Bin 3
        32'h3910_FFFF, 32'h3910_0002, 32'h3020_5555,
        // Reload of rows drained before
        32'h0000_0007, 32'h2300_0009, 32'h1220_0003
    };

    logic                                           clk;
    logic                                           arst_n;
    logic                                           init_finish;
    logic [NB*DW-1:0]                               cu_delta;
    logic [NB*eq_pkg::VERTEX_IDX_WIDTH-1:0]         cu_idx;
    eq_pkg::bin_mask_t                              cu_valid;
    eq_pkg::bin_mask_t                              cu_ready;
    eq_pkg::bin_mask_t                              cu_clean;
    logic                                           read_en;
    eq_pkg::row_idx_t                               row_idx;
    eq_pkg::bin_idx_t                               bin_idx;
    logic [eq_pkg::COL_NUM*DW-1:0]                  row_delta;
    logic                                           row_valid;
    logic                                           row_ready = 1'b0;

    // Reference model, sums wrap at 16 bits
    eq_pkg::delta_t model_sum [NB][eq_pkg::ROW_NUM][eq_pkg::COL_NUM];
    bit             model_occ [NB][eq_pkg::ROW_NUM];
    // Last granted bin, bin 0 comes first after reset
    int             last_bin;
    // Expected rows as {bin, row, deltas}
    logic [69:0]    exp_q [$];

    int   test_errs [6];
    int   checks;
    int   cycle_limit = 0;
    int   cycles      = 0;
    int   seed        = 1;
    int   rnd;
    logic drain_on;

    tb_clk_gen #(.PERIOD_NS(10), .RST_CYCLES(RST_CYCLES)) u_clk_gen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    eq_wrapper_half u_dut (
        .clk_i           (clk),
        .arst_n_i        (arst_n),
        .initialFinish_i (init_finish),
        .CUDelta_i       (cu_delta),
        .CUIdx_i         (cu_idx),
        .CUValid_i       (cu_valid),
        .CUReady_o       (cu_ready),
        .CUClean_o       (cu_clean),
        .readEn_i        (read_en),
        .rowIdx_o        (row_idx),
        .binIdx_o        (bin_idx),
        .rowDelta_o      (row_delta),
        .rowValid_o      (row_valid),
        .rowReady_i      (row_ready)
    );

    // Random back-pressure, enable taken at the edge
    always @(posedge clk) begin : ready_drive
        logic en;
        en = drain_on;
        #1;
        rnd       = $random(seed);
        row_ready = en & rnd[0];
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run still busy after %0d cycles", cycle_limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // ======================================================================
    // Helpers
    // ======================================================================
    // Distinct rows per load, for the run length
    function automatic int count_rows();
        bit seen [NB][eq_pkg::ROW_NUM];
        int n;
        n    = 0;
        seen = '{default: 1'b0};
        for (int i = 0; i < TBL_LEN; i++) begin
            if (i == TBL1_LEN) begin
                seen = '{default: 1'b0};
            end
            if (!seen[STIM_TBL[i][29:28]][STIM_TBL[i][27:24]]) begin
                n++;
            end
            seen[STIM_TBL[i][29:28]][STIM_TBL[i][27:24]] = 1'b1;
        end
        return n;
    endfunction

    function automatic eq_pkg::bin_mask_t touched_mask(input int lo, input int hi);
        eq_pkg::bin_mask_t mask;
        mask = '0;
        for (int i = lo; i < hi; i++) begin
            mask[STIM_TBL[i][29:28]] = 1'b1;
        end
        return mask;
    endfunction

    task automatic drive_slot();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input int t, input string name,
                               input logic [79:0] exp, input logic [79:0] act);
        checks++;
        assert (exp === act) else begin
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
            test_errs[t]++;
        end
    endtask

    // One table entry on its lane, held until ready, then folded into the model
    task automatic apply_entry(input int i, input int t);
        int               lane;
        eq_pkg::row_idx_t row;
        eq_pkg::col_idx_t col;
        eq_pkg::delta_t   d;
        lane = int'(STIM_TBL[i][29:28]);
        row  = STIM_TBL[i][27:24];
        col  = STIM_TBL[i][21:20];
        d    = STIM_TBL[i][15:0];
        cu_delta[lane*DW +: DW] = d;
        cu_idx[lane*8 +: 8]     = {row, eq_pkg::bin_idx_t'(lane), col};
        cu_valid[lane]          = 1'b1;
        @(negedge clk);
        while (!cu_ready[lane]) @(negedge clk);
        check_value(t, "idle while loading", 80'(0), 80'(row_valid));
        drive_slot();
        cu_valid[lane] = 1'b0;
        model_sum[lane][row][col] = model_sum[lane][row][col] + d;
        model_occ[lane][row]      = 1'b1;
    endtask

    // Round robin after the last grant, lowest row first
    task automatic predict_drain();
        logic [63:0] deltas;
        int          b;
        bit          found;
        found = 1'b1;
        while (found) begin
            found = 1'b0;
            for (int k = 1; k <= NB; k++) begin
                b = (last_bin + k) % NB;
                for (int r = 0; r < eq_pkg::ROW_NUM; r++) begin
                    if (!found && model_occ[b][r]) begin
                        for (int c = 0; c < eq_pkg::COL_NUM; c++) begin
                            deltas[c*DW +: DW] = model_sum[b][r][c];
                            model_sum[b][r][c] = '0;
                        end
                        exp_q.push_back({eq_pkg::bin_idx_t'(b), eq_pkg::row_idx_t'(r), deltas});
                        model_occ[b][r] = 1'b0;
                        last_bin        = b;
                        found           = 1'b1;
                    end
                end
            end
        end
    endtask

    task automatic drain_rows(input int val_t, input int hold_t);
        int          n_exp;
        int          n_rx;
        logic        hold;
        logic [69:0] prev;
        logic [69:0] act;
        n_exp       = exp_q.size();
        n_rx        = 0;
        hold        = 1'b0;
        prev        = '0;
        drain_on    = 1'b1;
        init_finish = 1'b1;
        // Runs until every bin is clean and the output stage is empty
        while (cu_clean != '1 || row_valid) begin
            @(negedge clk);
            act = {bin_idx, row_idx, row_delta};
            // Held row must not move under back-pressure
            if (hold) begin
                check_value(hold_t, "held row", 80'({1'b1, prev}), 80'({row_valid, act}));
            end
            if (row_valid && row_ready) begin
                n_rx++;
                if (exp_q.size() > 0) begin
                    check_value(val_t, $sformatf("drain row %0d", n_rx - 1),
                                80'(exp_q.pop_front()), 80'(act));
                end
            end
            hold = row_valid & ~row_ready;
            prev = act;
        end
        drive_slot();
        drain_on    = 1'b0;
        init_finish = 1'b0;
        // Nothing past the predicted rows
        repeat (3) @(negedge clk);
        check_value(hold_t, "no extra row", 80'(0), 80'(row_valid));
        check_value(hold_t, "row count", 80'(n_exp), 80'(n_rx));
    endtask

    task automatic report_test(input int t, input string name);
        $display("Test %0d %s: %s (%0d errors)", t, name,
                 test_errs[t] == 0 ? "ok" : "failed", test_errs[t]);
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial begin : main
        eq_pkg::bin_mask_t mask;
        int                total;
        init_finish = 1'b0;
        read_en     = 1'b0;
        cu_delta    = '0;
        cu_idx      = '0;
        cu_valid    = '0;
        drain_on    = 1'b0;
        checks      = 0;
        last_bin    = NB - 1;
        test_errs   = '{default: 0};
        model_sum   = '{default: '0};
        model_occ   = '{default: 1'b0};
        cycle_limit = 4 * (TBL_LEN + count_rows() + RST_CYCLES) + 200;
        wait (arst_n === 1'b1);
        drive_slot();

        @(negedge clk);
        check_value(1, "reset state", 80'({1'b0, 4'hF, 4'hF}),
                    80'({row_valid, cu_ready, cu_clean}));
        report_test(1, "reset state");

        // Reads enabled, initial load still running
        drive_slot();
        read_en = 1'b1;
        for (int i = 0; i < TBL1_LEN; i++) begin
            apply_entry(i, 2);
        end
        @(negedge clk);
        mask = ~touched_mask(0, TBL1_LEN);
        check_value(2, "clean after load", 80'(mask), 80'(cu_clean));
        report_test(2, "load before initial finish");

        predict_drain();
        drive_slot();
        drain_rows(3, 4);
        report_test(3, "drain row contents");
        report_test(4, "back-pressure and row count");

        check_value(5, "clean after drain", 80'(4'hF), 80'(cu_clean));
        drive_slot();
        for (int i = TBL1_LEN; i < TBL_LEN; i++) begin
            apply_entry(i, 5);
        end
        @(negedge clk);
        mask = ~touched_mask(TBL1_LEN, TBL_LEN);
        check_value(5, "clean after reload", 80'(mask), 80'(cu_clean));
        predict_drain();
        drive_slot();
        drain_rows(5, 5);
        check_value(5, "clean at end", 80'(4'hF), 80'(cu_clean));
        report_test(5, "reload after drain");

        total = 0;
        foreach (test_errs[t]) begin
            total += test_errs[t];
        end
        $display("Tests: 5, checks: %0d, errors: %0d", checks, total);
        if (total == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
eq_pkg.sv
event_bin.sv
queue_scheduler.sv
event_queues_half.sv
eq_wrapper_half.sv
tb_clk_gen.sv
tb_eq_wrapper_half.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run the testbench, judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/10ps -f compile.f \
    --top-module tb_eq_wrapper_half -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or run error"; exit 1; }
cat sim.log
grep -q "Simulation finished: FAIL" sim.log \
    && { echo "Result: failed"; exit 1; } \
    || echo "Result: passed"
